// ==== cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Processor side byte address.
// The byte is bits 1..0, the index is bits 12..2 and the tag is bits 15..13.
`define CACHE_ADDR_W   16
`define CACHE_INDEX_W  11
`define CACHE_TAG_W    3
`define CACHE_LINES    2048

`define DATA_W         32

// Main memory covers the whole byte address space, one word per entry.
`define MEM_WORDS      16384

// Cycles from the first cycle of a command to its done pulse.
`define MEM_LATENCY    4

`endif

// ==== cache_pkg.sv ====
package cache_pkg;

    ////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////

    // LOOKUP is visited again after every memory access. This means a
    // completed refill always ends in a regular hit.
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        WRITEBACK = 3'd2,
        REFILL    = 3'd3,
        COMPLETE  = 3'd4
    } ctrl_state_t;

    ////////////////////////////////////////
    // Main memory commands
    ////////////////////////////////////////

    // A command stays on the bus until memory answers with done.
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_cmd_t;

endpackage

// ==== cache_array_if.sv ====
`include "cache_params.svh"

interface cache_array_if;

    // Request side, driven by the controller.
    logic [`CACHE_ADDR_W-1:0] addr;
    logic                     we;
    logic                     is_word;
    logic [`DATA_W-1:0]       wdata;
    logic                     set_valid;
    logic                     set_dirty;
    logic                     valid_val;
    logic                     dirty_val;

    // Lookup results for the line selected by addr.
    logic                     hit;
    logic                     dirty;
    logic [`DATA_W-1:0]       rdata;
    logic [`CACHE_ADDR_W-1:0] victim_addr;

    modport ctrl (
        output addr,
        output we,
        output is_word,
        output wdata,
        output set_valid,
        output set_dirty,
        output valid_val,
        output dirty_val,
        input  hit,
        input  dirty,
        input  rdata,
        input  victim_addr
    );

    modport array (
        input  addr,
        input  we,
        input  is_word,
        input  wdata,
        input  set_valid,
        input  set_dirty,
        input  valid_val,
        input  dirty_val,
        output hit,
        output dirty,
        output rdata,
        output victim_addr
    );

endinterface

// ==== mem_if.sv ====
`include "cache_params.svh"

interface mem_if import cache_pkg::*; ();

    // The addr is a byte address, and memory ignores bits 1..0.
    mem_cmd_t                 cmd;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`DATA_W-1:0]       wdata;

    // The done signal is a one cycle pulse, and rdata is valid with it.
    logic [`DATA_W-1:0]       rdata;
    logic                     done;

    modport ctrl (
        output cmd,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    modport mem (
        input  cmd,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );

endinterface

// ==== cache_array.sv ====
`include "cache_params.svh"

module cache_array (
    input  logic         clk,
    input  logic         rst_n,
    cache_array_if.array bus
);

    logic [`DATA_W-1:0]       data_mem  [`CACHE_LINES];
    logic [`CACHE_TAG_W-1:0]  tag_mem   [`CACHE_LINES];
    logic                     valid_mem [`CACHE_LINES];
    logic                     dirty_mem [`CACHE_LINES];

    logic [`CACHE_INDEX_W-1:0] index;
    logic [`CACHE_TAG_W-1:0]   tag;
    logic [1:0]                byte_sel;

    logic [`CACHE_INDEX_W-1:0] init_cnt;
    logic                      init_done;

    assign byte_sel = bus.addr[1:0];
    assign index    = bus.addr[`CACHE_INDEX_W+1:2];
    assign tag      = bus.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    // Nothing hits and nothing is dirty until every status bit is swept.
    assign bus.hit         = init_done && valid_mem[index] && (tag_mem[index] == tag);
    assign bus.dirty       = init_done && dirty_mem[index];
    assign bus.rdata       = data_mem[index];
    assign bus.victim_addr = {tag_mem[index], index, 2'b00};

    ////////////////////////////////////////
    // Status sweep after reset
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == `CACHE_INDEX_W'(`CACHE_LINES - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // One line per cycle during the sweep, then only on controller strobes.
    always_ff @(posedge clk) begin
        if (!init_done) begin
            valid_mem[init_cnt] <= 1'b0;
            dirty_mem[init_cnt] <= 1'b0;
        end else begin
            if (bus.set_valid) begin
                valid_mem[index] <= bus.valid_val;
            end
            if (bus.set_dirty) begin
                dirty_mem[index] <= bus.dirty_val;
            end
        end
    end

    ////////////////////////////////////////
    // Data and tag writes
    ////////////////////////////////////////

    // Byte b sits at bits 8b+7..8b.
    always_ff @(posedge clk) begin
        if (bus.we) begin
            if (bus.is_word) begin
                data_mem[index] <= bus.wdata;
            end else begin
                data_mem[index][8*byte_sel +: 8] <= bus.wdata[7:0];
            end
            tag_mem[index] <= tag;
        end
    end

endmodule

// ==== cache_controller.sv ====
`include "cache_params.svh"

module cache_controller import cache_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  logic                     req_we,
    input  logic                     req_is_word,
    input  logic [`CACHE_ADDR_W-1:0] req_addr,
    input  logic [`DATA_W-1:0]       req_wdata,
    output logic [`DATA_W-1:0]       resp_rdata,
    output logic                     resp_ready,
    cache_array_if.ctrl              arr,
    mem_if.ctrl                      mem
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    logic [`CACHE_ADDR_W-1:0] held_addr;
    logic                     held_we;
    logic                     held_is_word;
    logic [`DATA_W-1:0]       held_wdata;
    logic [`DATA_W-1:0]       rdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // The request is taken once in IDLE and held for the whole access.
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            held_addr    <= req_addr;
            held_we      <= req_we;
            held_is_word <= req_is_word;
            held_wdata   <= req_wdata;
        end
        if (state == LOOKUP && arr.hit) begin
            rdata_q <= arr.rdata;
        end
    end

    assign resp_ready = (state == COMPLETE);
    assign resp_rdata = rdata_q;

    ////////////////////////////////////////
    // Next state and strobes
    ////////////////////////////////////////

    always_comb begin
        state_next    = state;
        arr.addr      = held_addr;
        arr.we        = 1'b0;
        arr.is_word   = 1'b1;
        arr.wdata     = held_wdata;
        arr.set_valid = 1'b0;
        arr.set_dirty = 1'b0;
        arr.valid_val = 1'b0;
        arr.dirty_val = 1'b0;
        mem.cmd       = MEM_NONE;
        mem.addr      = arr.victim_addr;
        mem.wdata     = arr.rdata;

        case (state)
            IDLE: begin
                if (req) begin
                    state_next = LOOKUP;
                end
            end

            LOOKUP: begin
                if (arr.hit) begin
                    state_next = COMPLETE;
                end else if (arr.dirty) begin
                    state_next = WRITEBACK;
                end else begin
                    state_next = REFILL;
                end
            end

            // The victim is clean once memory has it, so the second
            // lookup goes straight to the refill.
            WRITEBACK: begin
                mem.cmd = MEM_WRITE;
                if (mem.done) begin
                    arr.set_dirty = 1'b1;
                    arr.dirty_val = 1'b0;
                    state_next    = LOOKUP;
                end
            end

            REFILL: begin
                mem.cmd  = MEM_READ;
                mem.addr = {held_addr[`CACHE_ADDR_W-1:2], 2'b00};
                if (mem.done) begin
                    arr.we        = 1'b1;
                    arr.is_word   = 1'b1;
                    arr.wdata     = mem.rdata;
                    arr.set_valid = 1'b1;
                    arr.valid_val = 1'b1;
                    arr.set_dirty = 1'b1;
                    arr.dirty_val = 1'b0;
                    state_next    = LOOKUP;
                end
            end

            COMPLETE: begin
                if (held_we) begin
                    arr.we        = 1'b1;
                    arr.is_word   = held_is_word;
                    arr.set_dirty = 1'b1;
                    arr.dirty_val = 1'b1;
                end
                state_next = IDLE;
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

// ==== main_memory.sv ====
`include "cache_params.svh"

module main_memory import cache_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    mem_if.mem   bus
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [`DATA_W-1:0]             ram [`MEM_WORDS];
    logic [CNT_W-1:0]               cnt;
    logic [$clog2(`MEM_WORDS)-1:0]  word_idx;
    logic                           access_end;

    // Word i holds C0DE0000 plus i.
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ram[i] = `DATA_W'(32'hC0DE0000 + i);
        end
    end

    assign word_idx = bus.addr[`CACHE_ADDR_W-1:2];

    // The done cycle itself is not counted, so a command that follows
    // directly starts from zero.
    assign access_end = (bus.cmd != MEM_NONE) && !bus.done &&
                        (cnt == CNT_W'(`MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt      <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= access_end;
            if (access_end) begin
                cnt <= '0;
            end else if (bus.cmd != MEM_NONE && !bus.done) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access_end) begin
            if (bus.cmd == MEM_WRITE) begin
                ram[word_idx] <= bus.wdata;
            end else begin
                bus.rdata <= ram[word_idx];
            end
        end
    end

endmodule

// ==== cache_top.sv ====
`include "cache_params.svh"

module cache_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  logic                     req_we,
    input  logic                     req_is_word,
    input  logic [`CACHE_ADDR_W-1:0] req_addr,
    input  logic [`DATA_W-1:0]       req_wdata,
    output logic [`DATA_W-1:0]       resp_rdata,
    output logic                     resp_ready
);

    cache_array_if arr_bus ();
    mem_if         mem_bus ();

    ////////////////////////////////////////
    // Controller
    ////////////////////////////////////////

    cache_controller u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_we      (req_we),
        .req_is_word (req_is_word),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .resp_rdata  (resp_rdata),
        .resp_ready  (resp_ready),
        .arr         (arr_bus.ctrl),
        .mem         (mem_bus.ctrl)
    );

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    cache_array u_array (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (arr_bus.array)
    );

    main_memory u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mem_bus.mem)
    );

endmodule

// ==== cache_assert.sv ====
module cache_assert import cache_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input ctrl_state_t state,
    input logic        resp_ready,
    input mem_cmd_t    mem_cmd,
    input logic        mem_done
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    ////////////////////////////////////////
    // Processor response
    ////////////////////////////////////////

    ready_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        resp_ready |=> !resp_ready)
        else begin
            $error("resp_ready lasted more than one cycle");
            fail_count++;
        end

    // A response needs a lookup first, so it never follows IDLE directly.
    ready_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
        state == IDLE |=> !resp_ready)
        else begin
            $error("resp_ready came straight after IDLE");
            fail_count++;
        end

    ////////////////////////////////////////
    // Memory handshake
    ////////////////////////////////////////

    // A command may only change once memory has answered.
    cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_cmd != MEM_NONE && !mem_done) |=> $stable(mem_cmd))
        else begin
            $error("memory command changed before done");
            fail_count++;
        end

    done_with_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        mem_done |-> mem_cmd != MEM_NONE)
        else begin
            $error("memory done without a command");
            fail_count++;
        end

endmodule

// ==== tb_cache_top.sv ====
`include "cache_params.svh"

module tb_cache_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int COLD_READS   = 4;
    localparam int RANDOM_OPS   = 200;
    localparam int NUM_ACCESSES = 2 * COLD_READS + 2 + 8 + 3 + RANDOM_OPS;
    localparam int SWEEP_LIMIT  = `CACHE_LINES + 16;
    localparam int CYCLE_LIMIT  = NUM_ACCESSES * (3 * `MEM_LATENCY + 6) + SWEEP_LIMIT + 2;

    logic                     clk;
    logic                     rst_n;
    logic                     req;
    logic                     req_we;
    logic                     req_is_word;
    logic [`CACHE_ADDR_W-1:0] req_addr;
    logic [`DATA_W-1:0]       req_wdata;
    logic [`DATA_W-1:0]       resp_rdata;
    logic                     resp_ready;

    logic [`DATA_W-1:0] model_mem [`MEM_WORDS];
    logic [`CACHE_ADDR_W-1:0] cold_addr [COLD_READS];
    integer seed;
    int cycle_count = 0;

    cache_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_we      (req_we),
        .req_is_word (req_is_word),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .resp_rdata  (resp_rdata),
        .resp_ready  (resp_ready)
    );

    bind cache_controller cache_assert u_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .resp_ready (resp_ready),
        .mem_cmd    (mem.cmd),
        .mem_done   (mem.done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // Check and access tasks
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // Reads are checked against the model, writes update it.
    task automatic do_access(input logic we, input logic is_word,
                             input logic [`CACHE_ADDR_W-1:0] addr,
                             input logic [`DATA_W-1:0] wdata,
                             output logic [`DATA_W-1:0] rdata, output int cycles);
        logic [`CACHE_ADDR_W-3:0] widx;
        widx = addr[`CACHE_ADDR_W-1:2];
        @(posedge clk);
        #1;
        req         = 1'b1;
        req_we      = we;
        req_is_word = is_word;
        req_addr    = addr;
        req_wdata   = wdata;
        cycles      = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (resp_ready !== 1'b1);
        rdata = resp_rdata;
        req   = 1'b0;
        if (we) begin
            if (is_word) begin
                model_mem[widx] = wdata;
            end else begin
                model_mem[widx][8*addr[1:0] +: 8] = wdata[7:0];
            end
        end else begin
            check_value("resp_rdata", model_mem[widx], rdata);
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_cold_reads();
        logic [`DATA_W-1:0] rdata;
        int cycles;
        for (int i = 0; i < COLD_READS; i++) begin
            do_access(1'b0, 1'b1, cold_addr[i], '0, rdata, cycles);
            check_value("resp_rdata", 32'hC0DE0000 + cold_addr[i][`CACHE_ADDR_W-1:2], rdata);
        end
    endtask

    // A hit answers two cycles after the request.
    task automatic test_hit_reads();
        logic [`DATA_W-1:0] rdata;
        int cycles;
        for (int i = 0; i < COLD_READS; i++) begin
            do_access(1'b0, 1'b1, cold_addr[i], '0, rdata, cycles);
            check_value("resp_rdata", 32'hC0DE0000 + cold_addr[i][`CACHE_ADDR_W-1:2], rdata);
            check_value("hit latency", 32'd2, cycles);
        end
    endtask

    task automatic test_word_write();
        logic [`DATA_W-1:0] rdata;
        int cycles;
        do_access(1'b1, 1'b1, 16'h0200, 32'h1234_5678, rdata, cycles);
        do_access(1'b0, 1'b1, 16'h0200, '0, rdata, cycles);
        check_value("resp_rdata", 32'h1234_5678, rdata);
        check_value("hit latency", 32'd2, cycles);
    endtask

    // The upper wdata bits are junk and must not reach the line.
    task automatic test_byte_writes();
        logic [`DATA_W-1:0] rdata;
        logic [`DATA_W-1:0] expected;
        int cycles;
        expected = 32'hC0DE0000 + 16'h0300 / 4;
        for (int b = 0; b < 4; b++) begin
            do_access(1'b1, 1'b0, 16'h0300 + b, 32'hFFFF_FF00 | (8'h10 + b), rdata, cycles);
            expected[8*b +: 8] = 8'h10 + b;
            do_access(1'b0, 1'b1, 16'h0300, '0, rdata, cycles);
            check_value("resp_rdata", expected, rdata);
        end
    endtask

    // A and A plus 8192 share the index, so the dirty line goes out and back.
    task automatic test_conflict();
        logic [`DATA_W-1:0] rdata;
        int cycles;
        do_access(1'b1, 1'b1, 16'h0124, 32'hDEAD_BEEF, rdata, cycles);
        do_access(1'b0, 1'b1, 16'h2124, '0, rdata, cycles);
        check_value("resp_rdata", 32'hC0DE0000 + 16'h2124 / 4, rdata);
        do_access(1'b0, 1'b1, 16'h0124, '0, rdata, cycles);
        check_value("resp_rdata", 32'hDEAD_BEEF, rdata);
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] d;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] rdata;
        int cycles;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r    = $random(seed);
            d    = $random(seed);
            addr = {r[2:0], (r[3] ? 11'h0a5 : 11'h0a6), r[5:4]};
            case (r[7:6])
                2'd2:    do_access(1'b1, 1'b1, addr, d, rdata, cycles);
                2'd3:    do_access(1'b1, 1'b0, addr, d, rdata, cycles);
                default: do_access(1'b0, 1'b1, addr, '0, rdata, cycles);
            endcase
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = 1'b0;
        req_we      = 1'b0;
        req_is_word = 1'b1;
        req_addr    = '0;
        req_wdata   = '0;
        seed        = 32'ha3cb;
        cold_addr[0] = 16'h0000;
        cold_addr[1] = 16'h0104;
        cold_addr[2] = 16'h7ffc;
        cold_addr[3] = 16'hfff8;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            model_mem[i] = 32'hC0DE0000 + i;
        end

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // The array clears its status bits one line per cycle.
        for (int i = 0; i <= SWEEP_LIMIT; i++) begin
            if (i == SWEEP_LIMIT) begin
                $display("The cache status sweep did not end after reset");
                $display("Simulation FAILED");
                $fatal(1);
            end
            @(posedge clk);
            #1;
            if (DUT.u_array.init_done === 1'b1) begin
                break;
            end
        end

        test_cold_reads();
        test_hit_reads();
        test_word_write();
        test_byte_writes();
        test_conflict();
        test_random();

        repeat (2) @(posedge clk);
        if (DUT.u_ctrl.u_assert.fail_count != 0) begin
            $display("%0d protocol assertions failed", DUT.u_ctrl.u_assert.fail_count);
            $display("Simulation FAILED");
            $fatal(1);
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== list.f ====
+incdir+.
cache_pkg.sv
cache_array_if.sv
mem_if.sv
cache_array.sv
cache_controller.sv
main_memory.sv
cache_top.sv
cache_assert.sv
tb_cache_top.sv

// ==== Bender.yml ====
package:
  name: dm_cache

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - cache_array_if.sv
      - mem_if.sv
      - cache_array.sv
      - cache_controller.sv
      - main_memory.sv
      - cache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cache_assert.sv
      - tb_cache_top.sv
